/* source/hmc_flit_params.svh */
`ifndef HMC_FLIT_PARAMS_SVH
`define HMC_FLIT_PARAMS_SVH

// ----------------------------------------
// Beat geometry
// ----------------------------------------
// Four FLITs per beat, slot 0 in the low bits
`define HMC_FPW     4
`define HMC_FLIT_W  128
`define HMC_BEAT_W  512
// Valid, header and tail masks plus the error nibble
`define HMC_USER_W  16

// ----------------------------------------
// User side widths
// ----------------------------------------
`define HMC_DATA_W  256
// 32-byte granule, placed at header address bit 5
`define HMC_ADDR_W  27
`define HMC_TAG_W   9

// ----------------------------------------
// Commands and packet lengths
// ----------------------------------------
`define HMC_CMD_P_WR32  6'b011001
`define HMC_CMD_RD32    6'b110001
`define HMC_LNG_WR32    4'd3
`define HMC_LNG_RD32    4'd1

// Cycles to wait after the controller reports init done
`define HMC_INIT_WAIT   256

`endif

/* source/hmc_flit_pkg.sv */
`include "hmc_flit_params.svh"

package hmc_flit_pkg;

  // ----------------------------------------
  // Packet header, HMC field order
  // ----------------------------------------
  // Same layout for requests and read responses
  typedef struct packed {
    // Cube ID, zero for a single device
    logic [2:0]  cub;
    logic [2:0]  res_hi;
    // Byte address, low 5 bits zero for 32-byte access
    logic [33:0] adrs;
    logic [8:0]  tag;
    // Duplicate of the length field
    logic [3:0]  dln;
    // Packet length in FLITs, header and tail included
    logic [3:0]  lng;
    logic        res_lo;
    logic [5:0]  cmd;
  } hmc_hdr_t;

  // ----------------------------------------
  // One FLIT, two views of the same word
  // ----------------------------------------
  typedef union packed {
    // Head FLIT: header in the low word, tail word above it
    struct packed {
      logic [63:0] tail;
      hmc_hdr_t    hdr;
    } head;
    // Payload FLIT: two data words, lo comes first on the wire
    struct packed {
      logic [63:0] hi;
      logic [63:0] lo;
    } data;
  } hmc_flit_t;

  // ----------------------------------------
  // Per-beat user bits, one bit per slot
  // ----------------------------------------
  typedef struct packed {
    // Error response bits from the controller, not decoded
    logic [`HMC_USER_W-3*`HMC_FPW-1:0] err;
    logic [`HMC_FPW-1:0]               tail;
    logic [`HMC_FPW-1:0]               hdr;
    logic [`HMC_FPW-1:0]               valid;
  } hmc_user_t;

  // 32-byte payload of a write or a read response
  typedef logic [`HMC_DATA_W-1:0] hmc_data_t;

  // Request tag, returned in the response header
  typedef logic [`HMC_TAG_W-1:0] hmc_tag_t;

endpackage

/* source/hmc_req_packer.sv */
`include "hmc_flit_params.svh"

module hmc_req_packer (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        init_done_i,
  input  logic                        wr_req_i,
  input  logic [`HMC_ADDR_W-1:0]      wr_addr_i,
  input  hmc_flit_pkg::hmc_data_t     wr_data_i,
  input  logic                        rd_req_i,
  input  logic [`HMC_ADDR_W-1:0]      rd_addr_i,
  input  hmc_flit_pkg::hmc_tag_t      rd_tag_i,
  input  logic                        tx_ready_i,
  output logic                        wr_ready_o,
  output logic                        rd_ready_o,
  output logic                        tx_valid_o,
  output logic [`HMC_BEAT_W-1:0]      tx_data_o,
  output hmc_flit_pkg::hmc_user_t     tx_user_o
);

  localparam int SETTLE_W = $clog2(`HMC_INIT_WAIT + 1);

  logic [SETTLE_W-1:0]     settle_cnt_q;
  logic                    init_ok_q;
  logic                    can_accept;
  logic                    wr_acc;
  logic                    rd_acc;
  hmc_flit_pkg::hmc_tag_t  wr_tag_q;
  hmc_flit_pkg::hmc_flit_t wr_head;
  hmc_flit_pkg::hmc_flit_t wr_mid;
  hmc_flit_pkg::hmc_flit_t wr_last;
  hmc_flit_pkg::hmc_flit_t rd_head;
  logic                    tx_valid_q;
  logic [`HMC_BEAT_W-1:0]  tx_data_q;
  hmc_flit_pkg::hmc_user_t tx_user_q;

  // ----------------------------------------
  // Start-up gate
  // ----------------------------------------
  // Counting starts on the first init_done_i and then runs to the end
  always_ff @(posedge CLK) begin
    if (RST) begin
      settle_cnt_q <= '0;
      init_ok_q    <= 1'b0;
    end else if (!init_ok_q && (init_done_i || settle_cnt_q != '0)) begin
      settle_cnt_q <= settle_cnt_q + 1'b1;
      if (settle_cnt_q == SETTLE_W'(`HMC_INIT_WAIT - 1)) begin
        init_ok_q <= 1'b1;
      end
    end
  end

  // Stall while the held beat is still refused by the controller
  assign can_accept = init_ok_q && (!tx_valid_q || tx_ready_i);
  assign wr_acc     = wr_req_i && can_accept;
  assign rd_acc     = rd_req_i && can_accept;

  // ----------------------------------------
  // FLIT builders
  // ----------------------------------------
  always_comb begin
    // P_WR32 head, first data word rides in the upper half
    wr_head               = '0;
    wr_head.head.hdr.adrs = {{(34 - `HMC_ADDR_W - 5){1'b0}}, wr_addr_i, 5'b00000};
    wr_head.head.hdr.tag  = wr_tag_q;
    wr_head.head.hdr.dln  = `HMC_LNG_WR32;
    wr_head.head.hdr.lng  = `HMC_LNG_WR32;
    wr_head.head.hdr.cmd  = `HMC_CMD_P_WR32;
    wr_head.data.hi       = wr_data_i[63:0];
    // Middle FLIT is pure payload
    wr_mid = wr_data_i[191:64];
    // Last data word, tail left zero for the controller to fill
    wr_last         = '0;
    wr_last.data.lo = wr_data_i[255:192];
    // RD32 is a single head FLIT with the user tag
    rd_head               = '0;
    rd_head.head.hdr.adrs = {{(34 - `HMC_ADDR_W - 5){1'b0}}, rd_addr_i, 5'b00000};
    rd_head.head.hdr.tag  = rd_tag_i;
    rd_head.head.hdr.dln  = `HMC_LNG_RD32;
    rd_head.head.hdr.lng  = `HMC_LNG_RD32;
    rd_head.head.hdr.cmd  = `HMC_CMD_RD32;
  end

  // ----------------------------------------
  // TX beat register
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_valid_q <= 1'b0;
      wr_tag_q   <= hmc_flit_pkg::hmc_tag_t'(1);
    end else begin
      if (wr_acc || rd_acc) begin
        tx_valid_q <= 1'b1;
      end else if (tx_ready_i) begin
        tx_valid_q <= 1'b0;
      end
      // Posted writes are tagged internally
      if (wr_acc) begin
        wr_tag_q <= wr_tag_q + 1'b1;
      end
    end
  end

  // Write in slots 0 to 2, read in slot 3
  always_ff @(posedge CLK) begin
    if (wr_acc || rd_acc) begin
      tx_data_q <= {rd_acc ? rd_head : '0, wr_acc ? wr_last : '0,
                    wr_acc ? wr_mid : '0, wr_acc ? wr_head : '0};
      tx_user_q.err   <= '0;
      tx_user_q.valid <= {rd_acc, wr_acc, wr_acc, wr_acc};
      tx_user_q.hdr   <= {rd_acc, 2'b00, wr_acc};
      tx_user_q.tail  <= {rd_acc, wr_acc, 2'b00};
    end
  end

  assign wr_ready_o = can_accept;
  assign rd_ready_o = can_accept;
  assign tx_valid_o = tx_valid_q;
  assign tx_data_o  = tx_data_q;
  assign tx_user_o  = tx_user_q;

endmodule

/* source/hmc_rsp_align.sv */
`include "hmc_flit_params.svh"

module hmc_rsp_align (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    beat_take_i,
  input  logic [`HMC_BEAT_W-1:0]  rx_data_i,
  input  hmc_flit_pkg::hmc_user_t rx_user_i,
  output logic                    rsp0_valid_o,
  output logic                    rsp1_valid_o,
  output hmc_flit_pkg::hmc_data_t rsp0_data_o,
  output hmc_flit_pkg::hmc_data_t rsp1_data_o,
  output hmc_flit_pkg::hmc_tag_t  rsp0_tag_o,
  output hmc_flit_pkg::hmc_tag_t  rsp1_tag_o
);

  hmc_flit_pkg::hmc_flit_t slot [`HMC_FPW];
  hmc_flit_pkg::hmc_user_t u;
  logic                    whole0;
  logic                    whole1;
  logic                    start2;
  logic                    start3;
  logic                    cont2;
  logic                    cont3;
  logic                    pend2_q;
  logic                    pend3_q;
  logic [191:0]            part_data_q;
  hmc_flit_pkg::hmc_tag_t  part_tag_q;
  logic                    whole_vld;
  hmc_flit_pkg::hmc_data_t whole_data;
  hmc_flit_pkg::hmc_tag_t  whole_tag;
  logic                    cont_vld;
  hmc_flit_pkg::hmc_data_t cont_data;

  // Split the beat into FLIT slots
  always_comb begin
    for (int i = 0; i < `HMC_FPW; i++) begin
      slot[i] = rx_data_i[i*`HMC_FLIT_W +: `HMC_FLIT_W];
    end
  end

  assign u = rx_user_i;

  // ----------------------------------------
  // Start and completion cases
  // ----------------------------------------
  // Whole response in slots 0 to 2
  assign whole0 = u.valid[2:0] == 3'b111 && u.hdr[2:0] == 3'b001 && u.tail[2:0] == 3'b100;
  // Whole response in slots 1 to 3
  assign whole1 = u.valid[3:1] == 3'b111 && u.hdr[3:1] == 3'b001 && u.tail[3:1] == 3'b100;
  // Header in slot 2, last FLIT in slot 0 of the next beat
  assign start2 = u.valid[3:2] == 2'b11 && u.hdr[3:2] == 2'b01 && u.tail[3:2] == 2'b00;
  // Header in slot 3, last FLIT in slot 1 of the next beat
  assign start3 = u.valid[3] && u.hdr[3] && !u.tail[3];

  // Completion of a pending response, never a header in those slots
  assign cont2 = pend2_q && u.valid[0] && !u.hdr[0] && u.tail[0];
  assign cont3 = pend3_q && u.valid[1:0] == 2'b11 && u.hdr[1:0] == 2'b00 &&
                 u.tail[1:0] == 2'b10;

  // ----------------------------------------
  // Partial response register
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      pend2_q <= 1'b0;
      pend3_q <= 1'b0;
    end else if (beat_take_i) begin
      // A new partial may start in the same beat that ends the old one
      pend2_q <= start2 || (pend2_q && !cont2);
      pend3_q <= start3 || (pend3_q && !cont3);
    end
  end

  always_ff @(posedge CLK) begin
    if (beat_take_i && start2) begin
      // Header data word plus the whole of slot 3
      part_data_q <= {slot[3], slot[2].data.hi};
      part_tag_q  <= slot[2].head.hdr.tag;
    end else if (beat_take_i && start3) begin
      // Only the word next to the header so far
      part_data_q <= {128'd0, slot[3].data.hi};
      part_tag_q  <= slot[3].head.hdr.tag;
    end
  end

  // ----------------------------------------
  // Response lanes
  // ----------------------------------------
  always_comb begin
    whole_vld = beat_take_i && (whole0 || whole1);
    if (whole0) begin
      whole_data = {slot[2].data.lo, slot[1], slot[0].data.hi};
      whole_tag  = slot[0].head.hdr.tag;
    end else begin
      whole_data = {slot[3].data.lo, slot[2], slot[1].data.hi};
      whole_tag  = slot[1].head.hdr.tag;
    end
    cont_vld = beat_take_i && (cont2 || cont3);
    if (cont2) begin
      cont_data = {slot[0].data.lo, part_data_q};
    end else begin
      cont_data = {slot[1].data.lo, slot[0], part_data_q[63:0]};
    end
  end

  // The completed partial is older than anything starting in this beat
  assign rsp0_valid_o = cont_vld || whole_vld;
  assign rsp0_data_o  = cont_vld ? cont_data : whole_data;
  assign rsp0_tag_o   = cont_vld ? part_tag_q : whole_tag;

  // Second lane only when both a partial and a whole response end here
  assign rsp1_valid_o = cont_vld && whole_vld;
  assign rsp1_data_o  = whole_data;
  assign rsp1_tag_o   = whole_tag;

endmodule

/* source/hmc_rsp_queue.sv */
module hmc_rsp_queue (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    rsp0_valid_i,
  input  logic                    rsp1_valid_i,
  input  hmc_flit_pkg::hmc_data_t rsp0_data_i,
  input  hmc_flit_pkg::hmc_data_t rsp1_data_i,
  input  hmc_flit_pkg::hmc_tag_t  rsp0_tag_i,
  input  hmc_flit_pkg::hmc_tag_t  rsp1_tag_i,
  output logic                    rx_ready_o,
  output logic                    rsp_valid_o,
  output hmc_flit_pkg::hmc_data_t rsp_data_o,
  output hmc_flit_pkg::hmc_tag_t  rsp_tag_o
);

  localparam int DEPTH = 4;

  hmc_flit_pkg::hmc_data_t data_mem [DEPTH];
  hmc_flit_pkg::hmc_tag_t  tag_mem  [DEPTH];
  logic [1:0]              wr_ptr_q;
  logic [1:0]              rd_ptr_q;
  logic [2:0]              count_q;
  logic [1:0]              push_cnt;
  logic                    pop;

  assign push_cnt = 2'(rsp0_valid_i) + 2'(rsp1_valid_i);
  // No user back-pressure, head leaves every cycle
  assign pop      = count_q != 3'd0;

  // Lane 1 lands behind lane 0 when both push
  always_ff @(posedge CLK) begin
    if (rsp0_valid_i) begin
      data_mem[wr_ptr_q] <= rsp0_data_i;
      tag_mem[wr_ptr_q]  <= rsp0_tag_i;
    end
    if (rsp1_valid_i) begin
      data_mem[wr_ptr_q + 2'(rsp0_valid_i)] <= rsp1_data_i;
      tag_mem[wr_ptr_q + 2'(rsp0_valid_i)]  <= rsp1_tag_i;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + push_cnt;
      rd_ptr_q <= rd_ptr_q + 2'(pop);
      count_q  <= count_q + {1'b0, push_cnt} - {2'b00, pop};
    end
  end

  // Two free entries always left for a two-response beat
  assign rx_ready_o  = count_q <= 3'd2;
  assign rsp_valid_o = pop;
  assign rsp_data_o  = data_mem[rd_ptr_q];
  assign rsp_tag_o   = tag_mem[rd_ptr_q];

endmodule

/* source/hmc_flit_user.sv */
`include "hmc_flit_params.svh"

module hmc_flit_user (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        init_done_i,
  // User write port
  input  logic                        wr_req_i,
  input  logic [`HMC_ADDR_W-1:0]      wr_addr_i,
  input  hmc_flit_pkg::hmc_data_t     wr_data_i,
  output logic                        wr_ready_o,
  // User read port
  input  logic                        rd_req_i,
  input  logic [`HMC_ADDR_W-1:0]      rd_addr_i,
  input  hmc_flit_pkg::hmc_tag_t      rd_tag_i,
  output logic                        rd_ready_o,
  // TX stream toward the controller
  output logic                        tx_valid_o,
  input  logic                        tx_ready_i,
  output logic [`HMC_BEAT_W-1:0]      tx_data_o,
  output hmc_flit_pkg::hmc_user_t     tx_user_o,
  // RX stream from the controller
  input  logic                        rx_valid_i,
  output logic                        rx_ready_o,
  input  logic [`HMC_BEAT_W-1:0]      rx_data_i,
  input  hmc_flit_pkg::hmc_user_t     rx_user_i,
  // Read responses
  output logic                        rsp_valid_o,
  output hmc_flit_pkg::hmc_data_t     rsp_data_o,
  output hmc_flit_pkg::hmc_tag_t      rsp_tag_o
);

  logic                    beat_take;
  logic                    rsp0_valid;
  logic                    rsp1_valid;
  hmc_flit_pkg::hmc_data_t rsp0_data;
  hmc_flit_pkg::hmc_data_t rsp1_data;
  hmc_flit_pkg::hmc_tag_t  rsp0_tag;
  hmc_flit_pkg::hmc_tag_t  rsp1_tag;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  hmc_req_packer u_packer (
    .CLK         (CLK),
    .RST         (RST),
    .init_done_i (init_done_i),
    .wr_req_i    (wr_req_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .rd_tag_i    (rd_tag_i),
    .tx_ready_i  (tx_ready_i),
    .wr_ready_o  (wr_ready_o),
    .rd_ready_o  (rd_ready_o),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o),
    .tx_user_o   (tx_user_o)
  );

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  // Beat is taken only when the queue has room for two responses
  assign beat_take = rx_valid_i && rx_ready_o;

  hmc_rsp_align u_align (
    .CLK          (CLK),
    .RST          (RST),
    .beat_take_i  (beat_take),
    .rx_data_i    (rx_data_i),
    .rx_user_i    (rx_user_i),
    .rsp0_valid_o (rsp0_valid),
    .rsp1_valid_o (rsp1_valid),
    .rsp0_data_o  (rsp0_data),
    .rsp1_data_o  (rsp1_data),
    .rsp0_tag_o   (rsp0_tag),
    .rsp1_tag_o   (rsp1_tag)
  );

  hmc_rsp_queue u_queue (
    .CLK          (CLK),
    .RST          (RST),
    .rsp0_valid_i (rsp0_valid),
    .rsp1_valid_i (rsp1_valid),
    .rsp0_data_i  (rsp0_data),
    .rsp1_data_i  (rsp1_data),
    .rsp0_tag_i   (rsp0_tag),
    .rsp1_tag_i   (rsp1_tag),
    .rx_ready_o   (rx_ready_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_tag_o    (rsp_tag_o)
  );

endmodule

/* tb/tb_hmc_flit_user.sv */
`include "hmc_flit_params.svh"

module tb_hmc_flit_user;

  localparam logic [1:0] OP_WR       = 2'd0;
  localparam logic [1:0] OP_RD       = 2'd1;
  localparam logic [1:0] OP_WRRD     = 2'd2;
  localparam logic [1:0] OP_RSP      = 2'd3;
  localparam int         NUM_ENTRIES = 22;
  localparam int         CYCLE_LIMIT = `HMC_INIT_WAIT + 20 * NUM_ENTRIES;
  // Read response command code in the response header
  localparam logic [5:0] CMD_RD_RS   = 6'b111000;

  // Pair holds tx_ready_i low for requests and packs a response behind the previous one
  typedef struct packed {
    logic [1:0]             op;
    logic [`HMC_ADDR_W-1:0] addr;
    hmc_flit_pkg::hmc_tag_t tag;
    logic [1:0]             algn;
    logic                   pair;
  } entry_t;

  logic                    CLK;
  logic                    RST;
  logic                    init_done_i;
  logic                    wr_req_i;
  logic [`HMC_ADDR_W-1:0]  wr_addr_i;
  hmc_flit_pkg::hmc_data_t wr_data_i;
  logic                    wr_ready_o;
  logic                    rd_req_i;
  logic [`HMC_ADDR_W-1:0]  rd_addr_i;
  hmc_flit_pkg::hmc_tag_t  rd_tag_i;
  logic                    rd_ready_o;
  logic                    tx_valid_o;
  logic                    tx_ready_i;
  logic [`HMC_BEAT_W-1:0]  tx_data_o;
  hmc_flit_pkg::hmc_user_t tx_user_o;
  logic                    rx_valid_i;
  logic                    rx_ready_o;
  logic [`HMC_BEAT_W-1:0]  rx_data_i;
  hmc_flit_pkg::hmc_user_t rx_user_i;
  logic                    rsp_valid_o;
  hmc_flit_pkg::hmc_data_t rsp_data_o;
  hmc_flit_pkg::hmc_tag_t  rsp_tag_o;

  entry_t                  tbl [NUM_ENTRIES];
  hmc_flit_pkg::hmc_data_t exp_data_q [$];
  hmc_flit_pkg::hmc_tag_t  exp_tag_q [$];
  // RX beat under construction
  logic [`HMC_BEAT_W-1:0]  cur_data = '0;
  hmc_flit_pkg::hmc_user_t cur_user = '0;
  int                      pos = 0;
  int                      stall_cnt = 0;
  int                      cycle_cnt = 0;
  int                      wait_cnt;
  hmc_flit_pkg::hmc_tag_t  wr_tag_exp;

  hmc_flit_user hmc_flit_user_i (.*);

  always #2 CLK = ~CLK;

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timed out waiting on the DUT after %0d cycles", cycle_cnt);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", name, got, exp));
    end
  endtask

  // Compare the whole TX beat slot by slot, then the user bits
  task automatic check_beat(input hmc_flit_pkg::hmc_flit_t s0, input hmc_flit_pkg::hmc_flit_t s1,
                            input hmc_flit_pkg::hmc_flit_t s2, input hmc_flit_pkg::hmc_flit_t s3,
                            input hmc_flit_pkg::hmc_user_t eu);
    hmc_flit_pkg::hmc_flit_t exp_slot [`HMC_FPW];
    hmc_flit_pkg::hmc_flit_t got;
    exp_slot[0] = s0;
    exp_slot[1] = s1;
    exp_slot[2] = s2;
    exp_slot[3] = s3;
    for (int i = 0; i < `HMC_FPW; i++) begin
      got = tx_data_o[i*`HMC_FLIT_W +: `HMC_FLIT_W];
      if (got !== exp_slot[i]) begin
        report_error($sformatf("TX slot %0d is %h, expected %h", i, got, exp_slot[i]));
      end
    end
    if (tx_user_o !== eu) begin
      report_error($sformatf("TX user bits are %h, expected %h", tx_user_o, eu));
    end
  endtask

  task automatic check_rsp(input hmc_flit_pkg::hmc_data_t ed, input hmc_flit_pkg::hmc_tag_t et);
    if (rsp_tag_o !== et) begin
      report_error($sformatf("response tag is %h, expected %h", rsp_tag_o, et));
    end
    if (rsp_data_o !== ed) begin
      report_error($sformatf("response %h data is %h, expected %h", et, rsp_data_o, ed));
    end
  endtask

  function automatic hmc_flit_pkg::hmc_data_t rand_data();
    hmc_flit_pkg::hmc_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[i*32 +: 32] = $urandom;
    end
    return d;
  endfunction

  // Head FLIT with the 32-byte granule address at byte address bit 5
  function automatic hmc_flit_pkg::hmc_flit_t make_head(input logic [5:0] cmd,
      input logic [3:0] lng, input logic [`HMC_ADDR_W-1:0] addr,
      input hmc_flit_pkg::hmc_tag_t tag, input logic [63:0] word);
    hmc_flit_pkg::hmc_flit_t f;
    f               = '0;
    f.head.hdr.cmd  = cmd;
    f.head.hdr.lng  = lng;
    f.head.hdr.dln  = lng;
    f.head.hdr.tag  = tag;
    f.head.hdr.adrs = 34'(addr) << 5;
    f.data.hi       = word;
    return f;
  endfunction

  // ----------------------------------------
  // RX model
  // ----------------------------------------
  // Hold the beat until a cycle where rx_ready_o lets it through
  task automatic send_beat();
    logic taken;
    rx_valid_i = 1'b1;
    rx_data_i  = cur_data;
    rx_user_i  = cur_user;
    taken      = 1'b0;
    while (!taken) begin
      taken = rx_ready_o;
      if (!taken) begin
        stall_cnt = stall_cnt + 1;
      end
      @(posedge CLK);
      #1;
    end
    rx_valid_i = 1'b0;
  endtask

  // Fill the next free slot and send the beat once all four are filled
  task automatic put_flit(input hmc_flit_pkg::hmc_flit_t f, input logic v, input logic h,
                          input logic t);
    cur_data[pos*`HMC_FLIT_W +: `HMC_FLIT_W] = f;
    cur_user.valid[pos] = v;
    cur_user.hdr[pos]   = h;
    cur_user.tail[pos]  = t;
    pos = pos + 1;
    if (pos == `HMC_FPW) begin
      send_beat();
      pos      = 0;
      cur_data = '0;
      cur_user = '0;
    end
  endtask

  // Pad the open beat with empty slots
  task automatic flush_stream();
    while (pos != 0) begin
      put_flit('0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  // Three-FLIT read response placed with its header in slot algn
  task automatic add_response(input entry_t e);
    hmc_flit_pkg::hmc_data_t d;
    hmc_flit_pkg::hmc_flit_t f2;
    d = rand_data();
    if (!e.pair) begin
      flush_stream();
    end
    while (pos != int'(e.algn)) begin
      put_flit('0, 1'b0, 1'b0, 1'b0);
    end
    exp_data_q.push_back(d);
    exp_tag_q.push_back(e.tag);
    // Last FLIT carries the final data word and a tail word the DUT ignores
    f2         = '0;
    f2.data.lo = d[255:192];
    f2.data.hi = {$urandom, $urandom};
    put_flit(make_head(CMD_RD_RS, `HMC_LNG_WR32, '0, e.tag, d[63:0]), 1'b1, 1'b1, 1'b0);
    put_flit(d[191:64], 1'b1, 1'b0, 1'b0);
    put_flit(f2, 1'b1, 1'b0, 1'b1);
  endtask

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  task automatic apply_request(input entry_t e);
    hmc_flit_pkg::hmc_data_t d;
    logic                    do_wr;
    logic                    do_rd;
    logic [`HMC_ADDR_W-1:0]  ra;
    hmc_flit_pkg::hmc_flit_t s0;
    hmc_flit_pkg::hmc_flit_t s1;
    hmc_flit_pkg::hmc_flit_t s2;
    hmc_flit_pkg::hmc_flit_t s3;
    hmc_flit_pkg::hmc_user_t eu;
    d     = rand_data();
    do_wr = e.op == OP_WR || e.op == OP_WRRD;
    do_rd = e.op == OP_RD || e.op == OP_WRRD;
    // Inverted address on the read port so the two ports differ
    ra = ~e.addr;
    s0 = '0;
    s1 = '0;
    s2 = '0;
    s3 = '0;
    eu = '0;
    // Write packet masks in slots 0 to 2
    if (do_wr) begin
      s0         = make_head(`HMC_CMD_P_WR32, `HMC_LNG_WR32, e.addr, wr_tag_exp, d[63:0]);
      s1         = d[191:64];
      s2.data.lo = d[255:192];
      eu.valid   = 4'b0111;
      eu.hdr     = 4'b0001;
      eu.tail    = 4'b0100;
    end
    // Single-FLIT read sets bit 3 of every mask
    if (do_rd) begin
      s3          = make_head(`HMC_CMD_RD32, `HMC_LNG_RD32, ra, e.tag, 64'd0);
      eu.valid[3] = 1'b1;
      eu.hdr[3]   = 1'b1;
      eu.tail[3]  = 1'b1;
    end
    wr_req_i   = do_wr;
    wr_addr_i  = e.addr;
    wr_data_i  = d;
    rd_req_i   = do_rd;
    rd_addr_i  = ra;
    rd_tag_i   = e.tag;
    tx_ready_i = !e.pair;
    while (!wr_ready_o) begin
      @(posedge CLK);
      #1;
    end
    check_flag("rd_ready_o", rd_ready_o, 1'b1);
    @(posedge CLK);
    #1;
    wr_req_i = 1'b0;
    rd_req_i = 1'b0;
    check_flag("tx_valid_o after accept", tx_valid_o, 1'b1);
    check_beat(s0, s1, s2, s3, eu);
    // Back-pressure keeps the beat and blocks new requests
    if (e.pair) begin
      repeat (3) begin
        check_flag("wr_ready_o while held", wr_ready_o, 1'b0);
        check_flag("rd_ready_o while held", rd_ready_o, 1'b0);
        @(posedge CLK);
        #1;
        check_flag("tx_valid_o while held", tx_valid_o, 1'b1);
        check_beat(s0, s1, s2, s3, eu);
      end
      tx_ready_i = 1'b1;
    end
    @(posedge CLK);
    #1;
    check_flag("tx_valid_o after transfer", tx_valid_o, 1'b0);
    if (do_wr) begin
      wr_tag_exp = wr_tag_exp + 1'b1;
    end
  endtask

  // Every delivered response must match the oldest one sent
  always @(negedge CLK) begin
    if (!RST && rsp_valid_o) begin
      if (exp_tag_q.size() == 0) begin
        report_error("a response came out with none outstanding");
      end else begin
        check_rsp(exp_data_q.pop_front(), exp_tag_q.pop_front());
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    tbl[0]  = '{OP_WR,   27'h0000123, 9'h000, 2'd0, 1'b0};
    tbl[1]  = '{OP_WR,   27'h7ffffe0, 9'h000, 2'd0, 1'b0};
    tbl[2]  = '{OP_RD,   27'h0045678, 9'h1a5, 2'd0, 1'b0};
    tbl[3]  = '{OP_WRRD, 27'h1234567, 9'h0f0, 2'd0, 1'b1};
    tbl[4]  = '{OP_RD,   27'h3fffffe, 9'h155, 2'd0, 1'b1};
    tbl[5]  = '{OP_RSP,  27'h0, 9'h011, 2'd0, 1'b0};
    tbl[6]  = '{OP_RSP,  27'h0, 9'h022, 2'd1, 1'b1};
    tbl[7]  = '{OP_RSP,  27'h0, 9'h033, 2'd2, 1'b0};
    // Spanning tails share beats with new responses and the queue fills up
    tbl[8]  = '{OP_RSP,  27'h0, 9'h044, 2'd1, 1'b1};
    tbl[9]  = '{OP_RSP,  27'h0, 9'h055, 2'd0, 1'b1};
    tbl[10] = '{OP_RSP,  27'h0, 9'h066, 2'd3, 1'b1};
    tbl[11] = '{OP_RSP,  27'h0, 9'h077, 2'd2, 1'b1};
    tbl[12] = '{OP_RSP,  27'h0, 9'h088, 2'd1, 1'b1};
    tbl[13] = '{OP_RSP,  27'h0, 9'h099, 2'd0, 1'b1};
    tbl[14] = '{OP_RSP,  27'h0, 9'h0aa, 2'd3, 1'b1};
    tbl[15] = '{OP_RSP,  27'h0, 9'h0bb, 2'd2, 1'b1};
    tbl[16] = '{OP_RSP,  27'h0, 9'h0cc, 2'd1, 1'b1};
    // Back-to-back spanning responses
    tbl[17] = '{OP_RSP,  27'h0, 9'h0dd, 2'd3, 1'b0};
    tbl[18] = '{OP_RSP,  27'h0, 9'h0ee, 2'd3, 1'b1};
    tbl[19] = '{OP_RSP,  27'h0, 9'h0ff, 2'd2, 1'b0};
    tbl[20] = '{OP_RSP,  27'h0, 9'h100, 2'd2, 1'b1};
    tbl[21] = '{OP_WR,   27'h2aaaaaa, 9'h000, 2'd0, 1'b0};
    void'($urandom(32'h630c));
    CLK         = 1'b0;
    RST         = 1'b1;
    init_done_i = 1'b0;
    wr_req_i    = 1'b0;
    wr_addr_i   = '0;
    wr_data_i   = '0;
    rd_req_i    = 1'b0;
    rd_addr_i   = '0;
    rd_tag_i    = '0;
    tx_ready_i  = 1'b1;
    rx_valid_i  = 1'b0;
    rx_data_i   = '0;
    rx_user_i   = '0;
    wr_tag_exp  = 9'd1;
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b0;
    check_flag("tx_valid_o after reset", tx_valid_o, 1'b0);
    check_flag("wr_ready_o after reset", wr_ready_o, 1'b0);
    check_flag("rd_ready_o after reset", rd_ready_o, 1'b0);
    check_flag("rsp_valid_o after reset", rsp_valid_o, 1'b0);
    check_flag("rx_ready_o after reset", rx_ready_o, 1'b1);
    repeat (4) begin
      @(posedge CLK);
      #1;
      check_flag("wr_ready_o before init", wr_ready_o, 1'b0);
    end
    // Requests pending during the settling wait must not leak out
    init_done_i = 1'b1;
    wr_req_i    = 1'b1;
    rd_req_i    = 1'b1;
    wait_cnt    = 0;
    while (!wr_ready_o) begin
      check_flag("tx_valid_o while settling", tx_valid_o, 1'b0);
      check_flag("rd_ready_o while settling", rd_ready_o, 1'b0);
      @(posedge CLK);
      #1;
      wait_cnt = wait_cnt + 1;
    end
    wr_req_i = 1'b0;
    rd_req_i = 1'b0;
    if (wait_cnt != `HMC_INIT_WAIT) begin
      report_error($sformatf("ready rose after %0d cycles, expected %0d", wait_cnt,
                             `HMC_INIT_WAIT));
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].op == OP_RSP) begin
        add_response(tbl[i]);
      end else begin
        flush_stream();
        apply_request(tbl[i]);
      end
    end
    flush_stream();
    check_flag("rx_ready_o dropped under load", stall_cnt != 0, 1'b1);
    // Let the queue drain and allow a few idle cycles for stray responses
    for (int n = 0; n < 20 && exp_tag_q.size() != 0; n++) begin
      @(posedge CLK);
    end
    repeat (4) @(posedge CLK);
    if (exp_tag_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Error at time %0t: %0d responses never came out", $time, exp_tag_q.size());
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

/* src.f */
+incdir+source
source/hmc_flit_pkg.sv
source/hmc_req_packer.sv
source/hmc_rsp_align.sv
source/hmc_rsp_queue.sv
source/hmc_flit_user.sv
tb/tb_hmc_flit_user.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f src.f --top-module tb_hmc_flit_user -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
grep -q "all tests passed" sim.log && echo "simulation passed" \
  || { cat sim.log; echo "simulation failed"; exit 1; }
